// File: common/nvme_host_settings.svh
`ifndef NVME_HOST_SETTINGS_SVH
`define NVME_HOST_SETTINGS_SVH

// bus geometry
`define AXI_DATA_WIDTH 32
`define AXI_ADDR_WIDTH 32

`define PCIE_ADDR_WIDTH 48 // host byte address
`define SLOT_TAG_WIDTH 10

`define IO_QUEUE_COUNT 8
`define IRQ_SRC_COUNT 8

// fifo region, the write that pushes one completion
`define CQ_DOORBELL_WORD 6'd3

`endif

// File: common/axi_lite_pkg.sv
package axi_lite_pkg;

	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

	// address bits [9:8], valid only while [15:10] are zero
	typedef enum logic [1:0] {
		REG_CNTL = 2'd0,
		REG_PCIE = 2'd1, // nothing mapped here
		REG_NVME = 2'd2,
		REG_FIFO = 2'd3
	} reg_region_t;

endpackage

// File: common/nvme_reg_pkg.sv
`include "nvme_host_settings.svh"

package nvme_reg_pkg;

	typedef logic [7:0] queue_size_t;
	typedef logic [3:0] cq_vec_t; // target cq of an sq
	typedef logic [2:0] irq_vec_t;
	typedef logic [`PCIE_ADDR_WIDTH-3:0] host_addr_t; // dword address

	// bit positions in the mask, clear and set words
	typedef enum logic [2:0] {
		IRQ_LINK_UP,
		IRQ_CC_EN,
		IRQ_CC_SHN,
		IRQ_BRESP_ERR,
		IRQ_RRESP_ERR,
		IRQ_MREQ_ERR,
		IRQ_CPLD_ERR,
		IRQ_CPLD_LEN_ERR
	} irq_src_t;

	////////////////////////////////////////////////////////////
	// first completion fifo word

	typedef struct packed {
		logic [12:0] status;
		logic [3:0] sq_qid;
		logic [8:0] cid_hi; // cid[15:7]
		logic [`SLOT_TAG_WIDTH-1:0] slot_tag;
		logic [1:0] cpl_type;
	} cpl_slotted_t;

	typedef struct packed {
		logic [`SLOT_TAG_WIDTH-8:0] pad;
		logic [12:0] status;
		logic [3:0] sq_qid;
		logic [15:0] cid;
		logic [1:0] cpl_type;
	} cpl_direct_t;

	// slotted when the type is nonzero
	typedef union packed {
		cpl_slotted_t slotted;
		cpl_direct_t direct;
	} cpl_word0_u;

endpackage

// File: axi_lite/axi_lite_write_fsm.sv
`timescale 1ns/1ps
`include "nvme_host_settings.svh"

module axi_lite_write_fsm (
	input logic s_axi_aclk,
	input logic s_axi_aresetn,
	input logic awvalid,
	output logic awready,
	input logic [`AXI_ADDR_WIDTH-1:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [`AXI_DATA_WIDTH-1:0] wdata,
	output logic bvalid,
	input logic bready,
	output axi_lite_pkg::axi_resp_t bresp,
	input logic hcmd_cq_wr1_rdy_n,
	output logic hcmd_cq_wr1_en,
	output logic cntl_wr,
	output logic nvme_wr,
	output logic fifo_wr,
	output logic [5:0] wr_offset,
	output logic [`AXI_DATA_WIDTH-1:0] wr_data
);
	import axi_lite_pkg::*;

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_AW = 3'd1;
	localparam logic [2:0] S_W = 3'd2;
	localparam logic [2:0] S_B = 3'd3;
	localparam logic [2:0] S_WAIT_CQ = 3'd4;
	localparam logic [2:0] S_WR_CQ = 3'd5;

	logic [2:0] state;
	logic [2:0] state_nxt;
	logic [15:2] awaddr_q;
	logic b_first;
	logic wr_mapped;
	logic wr_doorbell;
	reg_region_t wr_region;

	assign wr_region = reg_region_t'(awaddr_q[9:8]);
	assign wr_mapped = (awaddr_q[15:10] == '0);
	assign wr_offset = awaddr_q[7:2];
	assign wr_doorbell = wr_mapped && (wr_region == REG_FIFO)
		&& (wr_offset == `CQ_DOORBELL_WORD);

	always_comb begin
		case (state)
			S_IDLE: state_nxt = awvalid ? S_AW : S_IDLE;
			S_AW: state_nxt = S_W;
			S_W: state_nxt = wvalid ? S_B : S_W;
			S_B: state_nxt = !bready ? S_B : (wr_doorbell ? S_WAIT_CQ : S_IDLE);
			S_WAIT_CQ: state_nxt = hcmd_cq_wr1_rdy_n ? S_WAIT_CQ : S_WR_CQ;
			default: state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
		if (!s_axi_aresetn) begin
			state <= S_IDLE;
			b_first <= 1'b0;
		end else begin
			state <= state_nxt;
			b_first <= (state == S_W) && wvalid; // marks first bvalid cycle
		end
	end

	always_ff @(posedge s_axi_aclk) begin
		if (state == S_IDLE && awvalid)
			awaddr_q <= awaddr[15:2];
		if (state == S_W && wvalid)
			wr_data <= wdata;
	end

	assign awready = (state == S_AW);
	assign wready = (state == S_W);
	assign bvalid = (state == S_B);
	assign bresp = AXI_RESP_OKAY;
	assign hcmd_cq_wr1_en = (state == S_WR_CQ);

	// one strobe per write
	assign cntl_wr = bvalid && b_first && wr_mapped && (wr_region == REG_CNTL);
	assign nvme_wr = bvalid && b_first && wr_mapped && (wr_region == REG_NVME);
	assign fifo_wr = bvalid && b_first && wr_mapped && (wr_region == REG_FIFO);

	// no push while the fifo is full
	a_cq_push_rdy: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
		hcmd_cq_wr1_en |-> !hcmd_cq_wr1_rdy_n);

endmodule

// File: axi_lite/axi_lite_read_fsm.sv
`timescale 1ns/1ps
`include "nvme_host_settings.svh"

module axi_lite_read_fsm (
	input logic s_axi_aclk,
	input logic s_axi_aresetn,
	input logic arvalid,
	output logic arready,
	input logic [`AXI_ADDR_WIDTH-1:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [`AXI_DATA_WIDTH-1:0] rdata,
	output axi_lite_pkg::axi_resp_t rresp,
	output logic [5:0] rd_offset,
	input logic [`AXI_DATA_WIDTH-1:0] cntl_rdata,
	input logic [`AXI_DATA_WIDTH-1:0] nvme_rdata,
	input logic [`AXI_DATA_WIDTH-1:0] fifo_rdata
);
	import axi_lite_pkg::*;

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_AR = 2'd1;
	localparam logic [1:0] S_CAP = 2'd2;
	localparam logic [1:0] S_DATA = 2'd3;

	logic [1:0] state;
	logic [1:0] state_nxt;
	logic [15:2] araddr_q;
	logic rd_mapped;
	reg_region_t rd_region;
	logic [`AXI_DATA_WIDTH-1:0] rd_sel;

	assign rd_region = reg_region_t'(araddr_q[9:8]);
	assign rd_mapped = (araddr_q[15:10] == '0);
	assign rd_offset = araddr_q[7:2];

	always_comb begin
		case (state)
			S_IDLE: state_nxt = arvalid ? S_AR : S_IDLE;
			S_AR: state_nxt = S_CAP;
			S_CAP: state_nxt = S_DATA;
			default: state_nxt = rready ? S_IDLE : S_DATA;
		endcase
	end

	always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
		if (!s_axi_aresetn)
			state <= S_IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		case (rd_region)
			REG_CNTL: rd_sel = cntl_rdata;
			REG_PCIE: rd_sel = '0;
			REG_NVME: rd_sel = nvme_rdata;
			default: rd_sel = fifo_rdata;
		endcase
		if (!rd_mapped)
			rd_sel = '0;
	end

	always_ff @(posedge s_axi_aclk) begin
		if (state == S_IDLE && arvalid)
			araddr_q <= araddr[15:2];
		if (state == S_CAP)
			rdata <= rd_sel; // held through the data phase
	end

	assign arready = (state == S_AR);
	assign rvalid = (state == S_DATA);
	assign rresp = AXI_RESP_OKAY;

	a_rdata_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
		rvalid && !rready |=> $stable(rdata));

endmodule

// File: source/irq_ctrl.sv
`timescale 1ns/1ps
`include "nvme_host_settings.svh"

module irq_ctrl (
	input logic s_axi_aclk,
	input logic s_axi_aresetn,
	input logic pcie_link_up,
	input logic m0_axi_bresp_err,
	input logic m0_axi_rresp_err,
	input logic pcie_mreq_err,
	input logic pcie_cpld_err,
	input logic pcie_cpld_len_err,
	input logic nvme_cc_en,
	input logic [1:0] nvme_cc_shn,
	input logic cntl_wr,
	input logic [5:0] wr_offset,
	input logic [`AXI_DATA_WIDTH-1:0] wr_data,
	input logic [5:0] rd_offset,
	output logic [`AXI_DATA_WIDTH-1:0] cntl_rdata,
	output logic dev_irq_assert,
	output logic pcie_user_logic_rst
);
	import nvme_reg_pkg::*;

	localparam logic [5:0] W_RST = 6'd0;
	localparam logic [5:0] W_MASK = 6'd1;
	localparam logic [5:0] W_CLEAR = 6'd2;
	localparam logic [5:0] W_SET = 6'd3;

	logic [2:0] bresp_err_sr; // m0 errors cross clocks
	logic [2:0] rresp_err_sr;
	logic link_up_q;
	logic cc_en_q;
	logic [1:0] cc_shn_q;
	logic mreq_err_q;
	logic cpld_err_q;
	logic cpld_len_err_q;
	logic [`IRQ_SRC_COUNT-1:0] irq_req;
	logic [`IRQ_SRC_COUNT-1:0] irq_mask;
	logic [`IRQ_SRC_COUNT-1:0] irq_clear;
	logic [`IRQ_SRC_COUNT-1:0] irq_set;

	////////////////////////////////////////////////////////////
	// source sampling, any toggle is a request

	always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
		if (!s_axi_aresetn) begin
			bresp_err_sr <= '0;
			rresp_err_sr <= '0;
			link_up_q <= 1'b0;
			cc_en_q <= 1'b0;
			cc_shn_q <= '0;
			mreq_err_q <= 1'b0;
			cpld_err_q <= 1'b0;
			cpld_len_err_q <= 1'b0;
			irq_req <= '0;
		end else begin
			bresp_err_sr <= {bresp_err_sr[1:0], m0_axi_bresp_err};
			rresp_err_sr <= {rresp_err_sr[1:0], m0_axi_rresp_err};
			link_up_q <= pcie_link_up;
			cc_en_q <= nvme_cc_en;
			cc_shn_q <= nvme_cc_shn;
			mreq_err_q <= pcie_mreq_err;
			cpld_err_q <= pcie_cpld_err;
			cpld_len_err_q <= pcie_cpld_len_err;
			irq_req[IRQ_LINK_UP] <= pcie_link_up ^ link_up_q;
			irq_req[IRQ_CC_EN] <= nvme_cc_en ^ cc_en_q;
			irq_req[IRQ_CC_SHN] <= (nvme_cc_shn != cc_shn_q);
			irq_req[IRQ_BRESP_ERR] <= bresp_err_sr[1] ^ bresp_err_sr[2];
			irq_req[IRQ_RRESP_ERR] <= rresp_err_sr[1] ^ rresp_err_sr[2];
			irq_req[IRQ_MREQ_ERR] <= pcie_mreq_err ^ mreq_err_q;
			irq_req[IRQ_CPLD_ERR] <= pcie_cpld_err ^ cpld_err_q;
			irq_req[IRQ_CPLD_LEN_ERR] <= pcie_cpld_len_err ^ cpld_len_err_q;
		end
	end

	////////////////////////////////////////////////////////////
	// mask, clear, set and the user logic reset

	always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
		if (!s_axi_aresetn) begin
			pcie_user_logic_rst <= 1'b0;
			irq_mask <= '0;
			irq_clear <= '0;
			irq_set <= '0;
			dev_irq_assert <= 1'b0;
		end else begin
			pcie_user_logic_rst <= cntl_wr && (wr_offset == W_RST) && wr_data[0];
			if (cntl_wr && wr_offset == W_MASK)
				irq_mask <= wr_data[`IRQ_SRC_COUNT-1:0];
			if (cntl_wr && wr_offset == W_CLEAR)
				irq_clear <= wr_data[`IRQ_SRC_COUNT-1:0]; // write one to clear
			else
				irq_clear <= '0;
			irq_set <= (irq_set | irq_req) & ~irq_clear & irq_mask;
			dev_irq_assert <= (irq_set != '0);
		end
	end

	always_comb begin
		cntl_rdata = '0;
		if (rd_offset == W_MASK)
			cntl_rdata[`IRQ_SRC_COUNT-1:0] = irq_mask;
		else if (rd_offset == W_SET)
			cntl_rdata[`IRQ_SRC_COUNT-1:0] = irq_set;
	end

	// mask feeds set one edge before set feeds the assert flop
	a_irq_needs_mask: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
		dev_irq_assert |-> $past(irq_mask != '0, 2));

endmodule

// File: nvme_regs/nvme_queue_regs.sv
`timescale 1ns/1ps
`include "nvme_host_settings.svh"

module nvme_queue_regs (
	input logic s_axi_aclk,
	input logic s_axi_aresetn,
	input logic nvme_wr,
	input logic [5:0] wr_offset,
	input logic [`AXI_DATA_WIDTH-1:0] wr_data,
	input logic [5:0] rd_offset,
	output logic [`AXI_DATA_WIDTH-1:0] nvme_rdata,
	input logic nvme_cc_en,
	input logic [1:0] nvme_cc_shn,
	output logic [1:0] nvme_csts_shst,
	output logic nvme_csts_rdy,
	output logic [3:0] reset_count,
	output logic [`IO_QUEUE_COUNT:0] sq_valid, // bit 0 is the admin queue
	output logic [`IO_QUEUE_COUNT:0] cq_valid,
	output logic [`IO_QUEUE_COUNT:0] io_cq_irq_en,
	output nvme_reg_pkg::queue_size_t [`IO_QUEUE_COUNT-1:0] io_sq_size,
	output nvme_reg_pkg::host_addr_t [`IO_QUEUE_COUNT-1:0] io_sq_bs_addr,
	output nvme_reg_pkg::cq_vec_t [`IO_QUEUE_COUNT-1:0] io_sq_cq_vec,
	output nvme_reg_pkg::queue_size_t [`IO_QUEUE_COUNT-1:0] io_cq_size,
	output nvme_reg_pkg::host_addr_t [`IO_QUEUE_COUNT-1:0] io_cq_bs_addr,
	output nvme_reg_pkg::irq_vec_t [`IO_QUEUE_COUNT-1:0] io_cq_iv
);
	localparam logic [5:0] W_CSTS = 6'd0;
	localparam logic [5:0] W_ADMIN = 6'd7;
	localparam int SQ_BASE = 8; // two words per queue
	localparam int CQ_BASE = SQ_BASE + 2 * `IO_QUEUE_COUNT;
	localparam int HI_W = `PCIE_ADDR_WIDTH - 32;

	logic cc_en_q;
	logic [1:0] cc_shn_q;

	always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
		if (!s_axi_aresetn) begin
			cc_en_q <= 1'b0;
			cc_shn_q <= '0;
			nvme_csts_shst <= '0;
			nvme_csts_rdy <= 1'b0;
			reset_count <= '0;
			sq_valid <= '0;
			cq_valid <= '0;
			io_cq_irq_en <= '0;
		end else begin
			cc_en_q <= nvme_cc_en;
			cc_shn_q <= nvme_cc_shn;
			if (nvme_wr && wr_offset == W_CSTS) begin
				reset_count <= wr_data[10:7];
				nvme_csts_shst <= wr_data[6:5];
				nvme_csts_rdy <= wr_data[4];
			end
			if (nvme_wr && wr_offset == W_ADMIN) begin
				io_cq_irq_en[0] <= wr_data[2];
				sq_valid[0] <= wr_data[1];
				cq_valid[0] <= wr_data[0];
			end
			for (int q = 0; q < `IO_QUEUE_COUNT; q++) begin
				if (nvme_wr && wr_offset == SQ_BASE + 2 * q + 1)
					sq_valid[q + 1] <= wr_data[16];
				if (nvme_wr && wr_offset == CQ_BASE + 2 * q + 1) begin
					io_cq_irq_en[q + 1] <= wr_data[20];
					cq_valid[q + 1] <= wr_data[16];
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// queue fields, even word low address, odd word the rest

	always_ff @(posedge s_axi_aclk) begin
		for (int q = 0; q < `IO_QUEUE_COUNT; q++) begin
			if (nvme_wr && wr_offset == SQ_BASE + 2 * q)
				io_sq_bs_addr[q][29:0] <= wr_data[31:2];
			if (nvme_wr && wr_offset == SQ_BASE + 2 * q + 1) begin
				io_sq_size[q] <= wr_data[31:24];
				io_sq_cq_vec[q] <= wr_data[20:17];
				io_sq_bs_addr[q][HI_W+29:30] <= wr_data[HI_W-1:0];
			end
			if (nvme_wr && wr_offset == CQ_BASE + 2 * q)
				io_cq_bs_addr[q][29:0] <= wr_data[31:2];
			if (nvme_wr && wr_offset == CQ_BASE + 2 * q + 1) begin
				io_cq_size[q] <= wr_data[31:24];
				io_cq_iv[q] <= wr_data[19:17];
				io_cq_bs_addr[q][HI_W+29:30] <= wr_data[HI_W-1:0];
			end
		end
	end

	always_comb begin
		nvme_rdata = '0;
		if (rd_offset == W_CSTS)
			nvme_rdata = {25'b0, nvme_csts_shst, nvme_csts_rdy, 1'b0, cc_shn_q, cc_en_q};
		if (rd_offset == W_ADMIN)
			nvme_rdata = {29'b0, io_cq_irq_en[0], sq_valid[0], cq_valid[0]};
		for (int q = 0; q < `IO_QUEUE_COUNT; q++) begin
			if (rd_offset == SQ_BASE + 2 * q)
				nvme_rdata = {io_sq_bs_addr[q][29:0], 2'b0};
			if (rd_offset == SQ_BASE + 2 * q + 1)
				nvme_rdata = {io_sq_size[q], 3'b0, io_sq_cq_vec[q], sq_valid[q + 1],
					io_sq_bs_addr[q][HI_W+29:30]};
			if (rd_offset == CQ_BASE + 2 * q)
				nvme_rdata = {io_cq_bs_addr[q][29:0], 2'b0};
			if (rd_offset == CQ_BASE + 2 * q + 1)
				nvme_rdata = {io_cq_size[q], 3'b0, io_cq_irq_en[q + 1], io_cq_iv[q],
					cq_valid[q + 1], io_cq_bs_addr[q][HI_W+29:30]};
		end
	end

endmodule

// File: nvme_regs/cpl_entry_regs.sv
`timescale 1ns/1ps
`include "nvme_host_settings.svh"

module cpl_entry_regs (
	input logic s_axi_aclk,
	input logic fifo_wr,
	input logic [5:0] wr_offset,
	input logic [`AXI_DATA_WIDTH-1:0] wr_data,
	input logic [5:0] rd_offset,
	output logic [`AXI_DATA_WIDTH-1:0] fifo_rdata,
	output nvme_reg_pkg::cpl_word0_u hcmd_cq_wr1_data0,
	output logic [35:0] hcmd_cq_wr1_data1
);
	localparam logic [5:0] W_QID_CID = 6'd1;
	localparam logic [5:0] W_SPECIFIC = 6'd2;

	logic [3:0] cpl_sq_qid;
	logic [15:0] cpl_cid;
	logic [31:0] cpl_specific;
	logic [14:0] cpl_status;
	logic [1:0] cpl_type;
	logic [`SLOT_TAG_WIDTH-1:0] cpl_slot_tag;

	always_ff @(posedge s_axi_aclk) begin
		if (fifo_wr && wr_offset == W_QID_CID)
			{cpl_sq_qid, cpl_cid} <= wr_data[19:0];
		if (fifo_wr && wr_offset == W_SPECIFIC)
			cpl_specific <= wr_data;
		if (fifo_wr && wr_offset == `CQ_DOORBELL_WORD) begin
			cpl_status <= wr_data[31:17];
			cpl_type <= wr_data[15:14];
			cpl_slot_tag <= wr_data[`SLOT_TAG_WIDTH-1:0];
		end
	end

	always_comb begin
		case (rd_offset)
			W_QID_CID: fifo_rdata = {12'b0, cpl_sq_qid, cpl_cid};
			W_SPECIFIC: fifo_rdata = cpl_specific;
			`CQ_DOORBELL_WORD: fifo_rdata = {cpl_status, 1'b0, cpl_type,
				{(14 - `SLOT_TAG_WIDTH){1'b0}}, cpl_slot_tag};
			default: fifo_rdata = '0;
		endcase
	end

	// typed entries carry the slot tag in place of the low cid bits
	always_comb begin
		if (cpl_type != 2'b00) begin
			hcmd_cq_wr1_data0.slotted.status = cpl_status[12:0];
			hcmd_cq_wr1_data0.slotted.sq_qid = cpl_sq_qid;
			hcmd_cq_wr1_data0.slotted.cid_hi = cpl_cid[15:7];
			hcmd_cq_wr1_data0.slotted.slot_tag = cpl_slot_tag;
			hcmd_cq_wr1_data0.slotted.cpl_type = cpl_type;
		end else begin
			hcmd_cq_wr1_data0.direct.pad = '0;
			hcmd_cq_wr1_data0.direct.status = cpl_status[12:0];
			hcmd_cq_wr1_data0.direct.sq_qid = cpl_sq_qid;
			hcmd_cq_wr1_data0.direct.cid = cpl_cid;
			hcmd_cq_wr1_data0.direct.cpl_type = cpl_type;
		end
	end

	assign hcmd_cq_wr1_data1 = {2'b00, cpl_specific, cpl_status[14:13]};

endmodule

// File: source/nvme_host_regs_top.sv
`timescale 1ns/1ps
`include "nvme_host_settings.svh"

module nvme_host_regs_top (
	input logic s_axi_aclk,
	input logic s_axi_aresetn,
	input logic s_axi_awvalid,
	output logic s_axi_awready,
	input logic [`AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
	input logic s_axi_wvalid,
	output logic s_axi_wready,
	input logic [`AXI_DATA_WIDTH-1:0] s_axi_wdata,
	output logic s_axi_bvalid,
	input logic s_axi_bready,
	output axi_lite_pkg::axi_resp_t s_axi_bresp,
	input logic s_axi_arvalid,
	output logic s_axi_arready,
	input logic [`AXI_ADDR_WIDTH-1:0] s_axi_araddr,
	output logic s_axi_rvalid,
	input logic s_axi_rready,
	output logic [`AXI_DATA_WIDTH-1:0] s_axi_rdata,
	output axi_lite_pkg::axi_resp_t s_axi_rresp,
	input logic pcie_link_up,
	input logic nvme_cc_en,
	input logic [1:0] nvme_cc_shn,
	input logic m0_axi_bresp_err,
	input logic m0_axi_rresp_err,
	input logic pcie_mreq_err,
	input logic pcie_cpld_err,
	input logic pcie_cpld_len_err,
	output logic dev_irq_assert,
	output logic pcie_user_logic_rst,
	output logic [1:0] nvme_csts_shst,
	output logic nvme_csts_rdy,
	output logic [3:0] reset_count,
	output logic [`IO_QUEUE_COUNT:0] sq_valid,
	output logic [`IO_QUEUE_COUNT:0] cq_valid,
	output logic [`IO_QUEUE_COUNT:0] io_cq_irq_en,
	output nvme_reg_pkg::queue_size_t [`IO_QUEUE_COUNT-1:0] io_sq_size,
	output nvme_reg_pkg::host_addr_t [`IO_QUEUE_COUNT-1:0] io_sq_bs_addr,
	output nvme_reg_pkg::cq_vec_t [`IO_QUEUE_COUNT-1:0] io_sq_cq_vec,
	output nvme_reg_pkg::queue_size_t [`IO_QUEUE_COUNT-1:0] io_cq_size,
	output nvme_reg_pkg::host_addr_t [`IO_QUEUE_COUNT-1:0] io_cq_bs_addr,
	output nvme_reg_pkg::irq_vec_t [`IO_QUEUE_COUNT-1:0] io_cq_iv,
	input logic hcmd_cq_wr1_rdy_n, // completion fifo full
	output logic hcmd_cq_wr1_en,
	output nvme_reg_pkg::cpl_word0_u hcmd_cq_wr1_data0,
	output logic [35:0] hcmd_cq_wr1_data1
);
	logic cntl_wr;
	logic nvme_wr;
	logic fifo_wr;
	logic [5:0] wr_offset;
	logic [`AXI_DATA_WIDTH-1:0] wr_data;
	logic [5:0] rd_offset;
	logic [`AXI_DATA_WIDTH-1:0] cntl_rdata;
	logic [`AXI_DATA_WIDTH-1:0] nvme_rdata;
	logic [`AXI_DATA_WIDTH-1:0] fifo_rdata;

	////////////////////////////////////////////////////////////
	// bus side

	axi_lite_write_fsm i_axi_lite_write_fsm (
		.awvalid(s_axi_awvalid),
		.awready(s_axi_awready),
		.awaddr(s_axi_awaddr),
		.wvalid(s_axi_wvalid),
		.wready(s_axi_wready),
		.wdata(s_axi_wdata),
		.bvalid(s_axi_bvalid),
		.bready(s_axi_bready),
		.bresp(s_axi_bresp),
		.*
	);

	axi_lite_read_fsm i_axi_lite_read_fsm (
		.arvalid(s_axi_arvalid),
		.arready(s_axi_arready),
		.araddr(s_axi_araddr),
		.rvalid(s_axi_rvalid),
		.rready(s_axi_rready),
		.rdata(s_axi_rdata),
		.rresp(s_axi_rresp),
		.*
	);

	////////////////////////////////////////////////////////////
	// register regions

	irq_ctrl i_irq_ctrl (.*);

	nvme_queue_regs i_nvme_queue_regs (.*);

	cpl_entry_regs i_cpl_entry_regs (.*);

endmodule

// File: bench/tb_nvme_host_regs.sv
`timescale 1ns/1ps
`include "nvme_host_settings.svh"

module tb_nvme_host_regs;

	localparam int TIMEOUT_CYCLES = 20000;
	localparam logic [31:0] CNTL_BASE = 32'h0000_0000;
	localparam logic [31:0] PCIE_BASE = 32'h0000_0100;
	localparam logic [31:0] NVME_BASE = 32'h0000_0200;
	localparam logic [31:0] FIFO_BASE = 32'h0000_0300;

	logic s_axi_aclk;
	logic s_axi_aresetn;
	logic s_axi_awvalid;
	logic s_axi_awready;
	logic [`AXI_ADDR_WIDTH-1:0] s_axi_awaddr;
	logic s_axi_wvalid;
	logic s_axi_wready;
	logic [`AXI_DATA_WIDTH-1:0] s_axi_wdata;
	logic s_axi_bvalid;
	logic s_axi_bready;
	axi_lite_pkg::axi_resp_t s_axi_bresp;
	logic s_axi_arvalid;
	logic s_axi_arready;
	logic [`AXI_ADDR_WIDTH-1:0] s_axi_araddr;
	logic s_axi_rvalid;
	logic s_axi_rready;
	logic [`AXI_DATA_WIDTH-1:0] s_axi_rdata;
	axi_lite_pkg::axi_resp_t s_axi_rresp;
	logic pcie_link_up;
	logic nvme_cc_en;
	logic [1:0] nvme_cc_shn;
	logic m0_axi_bresp_err;
	logic m0_axi_rresp_err;
	logic pcie_mreq_err;
	logic pcie_cpld_err;
	logic pcie_cpld_len_err;
	logic dev_irq_assert;
	logic pcie_user_logic_rst;
	logic [1:0] nvme_csts_shst;
	logic nvme_csts_rdy;
	logic [3:0] reset_count;
	logic [`IO_QUEUE_COUNT:0] sq_valid;
	logic [`IO_QUEUE_COUNT:0] cq_valid;
	logic [`IO_QUEUE_COUNT:0] io_cq_irq_en;
	nvme_reg_pkg::queue_size_t [`IO_QUEUE_COUNT-1:0] io_sq_size;
	nvme_reg_pkg::host_addr_t [`IO_QUEUE_COUNT-1:0] io_sq_bs_addr;
	nvme_reg_pkg::cq_vec_t [`IO_QUEUE_COUNT-1:0] io_sq_cq_vec;
	nvme_reg_pkg::queue_size_t [`IO_QUEUE_COUNT-1:0] io_cq_size;
	nvme_reg_pkg::host_addr_t [`IO_QUEUE_COUNT-1:0] io_cq_bs_addr;
	nvme_reg_pkg::irq_vec_t [`IO_QUEUE_COUNT-1:0] io_cq_iv;
	logic hcmd_cq_wr1_rdy_n;
	logic hcmd_cq_wr1_en;
	nvme_reg_pkg::cpl_word0_u hcmd_cq_wr1_data0;
	logic [35:0] hcmd_cq_wr1_data1;

	int error_count;
	int cycle_count;
	int push_count;
	int rst_pulse_count;
	logic [37:0] push_data0;
	logic [35:0] push_data1;
	logic [`IO_QUEUE_COUNT:0] exp_sq_valid;
	logic [`IO_QUEUE_COUNT:0] exp_cq_valid;
	logic [`IO_QUEUE_COUNT:0] exp_irq_en;

	nvme_host_regs_top i_nvme_host_regs_top (.*);

	always #5 s_axi_aclk = ~s_axi_aclk;

	always @(posedge s_axi_aclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// pulse counters, data taken at the push
	always @(posedge s_axi_aclk) begin
		if (hcmd_cq_wr1_en) begin
			push_count <= push_count + 1;
			push_data0 <= hcmd_cq_wr1_data0;
			push_data1 <= hcmd_cq_wr1_data1;
		end
		if (pcie_user_logic_rst)
			rst_pulse_count <= rst_pulse_count + 1;
	end

	function automatic logic [31:0] reg_addr(input logic [31:0] base, input int word);
		return base + 32'(word * 4);
	endfunction

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("ERROR: %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// bus tasks

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
		int hold;
		hold = $urandom_range(0, 3);
		@(posedge s_axi_aclk);
		s_axi_awaddr <= addr;
		s_axi_awvalid <= 1'b1;
		s_axi_wdata <= data;
		s_axi_wvalid <= 1'b1;
		do @(posedge s_axi_aclk); while (!s_axi_awready);
		s_axi_awvalid <= 1'b0;
		do @(posedge s_axi_aclk); while (!s_axi_wready);
		s_axi_wvalid <= 1'b0;
		repeat (hold) @(posedge s_axi_aclk); // bready held off
		s_axi_bready <= 1'b1;
		do @(posedge s_axi_aclk); while (!s_axi_bvalid);
		s_axi_bready <= 1'b0;
		check_value("bresp", s_axi_bresp, 2'b00);
	endtask

	task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
		int hold;
		hold = $urandom_range(0, 3);
		@(posedge s_axi_aclk);
		s_axi_araddr <= addr;
		s_axi_arvalid <= 1'b1;
		do @(posedge s_axi_aclk); while (!s_axi_arready);
		s_axi_arvalid <= 1'b0;
		repeat (hold) @(posedge s_axi_aclk);
		s_axi_rready <= 1'b1;
		do @(posedge s_axi_aclk); while (!s_axi_rvalid);
		data = s_axi_rdata;
		s_axi_rready <= 1'b0;
		check_value("rresp", s_axi_rresp, 2'b00);
	endtask

	task automatic check_read(input logic [31:0] addr, input logic [31:0] exp, input string what);
		logic [31:0] data;
		axi_read(addr, data);
		if (data !== exp) begin
			error_count++;
			$display("ERROR: %0t: %s at 0x%08h read 0x%08h, expected 0x%08h",
				$time, what, addr, data, exp);
		end
	endtask

	// bit order follows the set word
	task automatic toggle_sources(input logic [7:0] bits);
		@(posedge s_axi_aclk);
		pcie_link_up <= pcie_link_up ^ bits[0];
		nvme_cc_en <= nvme_cc_en ^ bits[1];
		nvme_cc_shn[0] <= nvme_cc_shn[0] ^ bits[2];
		m0_axi_bresp_err <= m0_axi_bresp_err ^ bits[3];
		m0_axi_rresp_err <= m0_axi_rresp_err ^ bits[4];
		pcie_mreq_err <= pcie_mreq_err ^ bits[5];
		pcie_cpld_err <= pcie_cpld_err ^ bits[6];
		pcie_cpld_len_err <= pcie_cpld_len_err ^ bits[7];
	endtask

	////////////////////////////////////////////////////////////
	// directed tests

	task automatic test_reset();
		check_value("handshake outputs after reset",
			{s_axi_awready, s_axi_wready, s_axi_bvalid, s_axi_arready, s_axi_rvalid}, '0);
		check_value("control outputs after reset",
			{hcmd_cq_wr1_en, pcie_user_logic_rst, dev_irq_assert}, '0);
		check_value("queue valid and irq enables", {sq_valid, cq_valid, io_cq_irq_en}, '0);
		check_value("status outputs", {nvme_csts_shst, nvme_csts_rdy, reset_count}, '0);
		check_read(reg_addr(NVME_BASE, 0), '0, "nvme status after reset");
		check_read(reg_addr(NVME_BASE, 7), '0, "admin queue after reset");
		check_read(reg_addr(CNTL_BASE, 1), '0, "irq mask after reset");
		check_read(reg_addr(CNTL_BASE, 3), '0, "irq set after reset");
	endtask

	task automatic test_queue_config();
		int q;
		logic [31:0] sq_lo;
		logic [31:0] sq_hi;
		logic [31:0] cq_lo;
		logic [31:0] cq_hi;
		logic [2:0] admin;
		q = $urandom_range(0, `IO_QUEUE_COUNT - 1);
		sq_lo = $urandom;
		sq_hi = $urandom;
		cq_lo = $urandom;
		cq_hi = $urandom;
		admin = 3'($urandom);
		axi_write(reg_addr(NVME_BASE, 7), {29'b0, admin});
		axi_write(reg_addr(NVME_BASE, 8 + 2 * q), sq_lo);
		axi_write(reg_addr(NVME_BASE, 9 + 2 * q), sq_hi);
		axi_write(reg_addr(NVME_BASE, 24 + 2 * q), cq_lo);
		axi_write(reg_addr(NVME_BASE, 25 + 2 * q), cq_hi);
		check_read(reg_addr(NVME_BASE, 7), {29'b0, admin}, "admin queue");
		check_read(reg_addr(NVME_BASE, 8 + 2 * q), {sq_lo[31:2], 2'b00}, "sq address low");
		check_read(reg_addr(NVME_BASE, 9 + 2 * q), sq_hi & 32'hff1f_ffff, "sq config");
		check_read(reg_addr(NVME_BASE, 24 + 2 * q), {cq_lo[31:2], 2'b00}, "cq address low");
		check_read(reg_addr(NVME_BASE, 25 + 2 * q), cq_hi & 32'hff1f_ffff, "cq config");

		// valid bits of every queue written so far
		exp_sq_valid[0] = admin[1];
		exp_sq_valid[q + 1] = sq_hi[16];
		exp_cq_valid[0] = admin[0];
		exp_cq_valid[q + 1] = cq_hi[16];
		exp_irq_en[0] = admin[2];
		exp_irq_en[q + 1] = cq_hi[20];
		check_value("sq_valid port", sq_valid, exp_sq_valid);
		check_value("cq_valid port", cq_valid, exp_cq_valid);
		check_value("io_cq_irq_en port", io_cq_irq_en, exp_irq_en);
		check_value("io_sq_size port", io_sq_size[q], sq_hi[31:24]);
		check_value("io_sq_cq_vec port", io_sq_cq_vec[q], sq_hi[20:17]);
		check_value("io_sq_bs_addr port", io_sq_bs_addr[q], {sq_hi[15:0], sq_lo[31:2]});
		check_value("io_cq_size port", io_cq_size[q], cq_hi[31:24]);
		check_value("io_cq_iv port", io_cq_iv[q], cq_hi[19:17]);
		check_value("io_cq_bs_addr port", io_cq_bs_addr[q], {cq_hi[15:0], cq_lo[31:2]});

		check_read(reg_addr(NVME_BASE, 5), '0, "unmapped nvme word");
		check_read(reg_addr(PCIE_BASE, 0), '0, "pcie region word");
		check_read(32'h0000_0400, '0, "address above the regions");
	endtask

	task automatic test_interrupts();
		logic [7:0] mask;
		logic [7:0] toggled;
		mask = {1'b0, 6'($urandom), 1'b1}; // source 7 always masked off
		toggled = 8'($urandom) | 8'h01;
		axi_write(reg_addr(CNTL_BASE, 1), {24'b0, mask});
		check_read(reg_addr(CNTL_BASE, 1), {24'b0, mask}, "irq mask");
		toggle_sources(toggled);
		repeat (8) @(posedge s_axi_aclk);
		check_read(reg_addr(CNTL_BASE, 3), {24'b0, toggled & mask}, "irq set bits");
		check_value("dev_irq_assert with set bits", dev_irq_assert, 1'b1);

		axi_write(reg_addr(CNTL_BASE, 2), 32'h0000_00ff);
		repeat (4) @(posedge s_axi_aclk);
		check_read(reg_addr(CNTL_BASE, 3), '0, "irq set bits after clear");
		check_value("dev_irq_assert after clear", dev_irq_assert, 1'b0);

		toggle_sources(~mask);
		repeat (8) @(posedge s_axi_aclk);
		check_read(reg_addr(CNTL_BASE, 3), '0, "set bits from masked-off sources");
		check_value("dev_irq_assert from masked-off sources", dev_irq_assert, 1'b0);
	endtask

	task automatic test_cpl_push(input logic [1:0] cpl_type);
		logic [3:0] qid;
		logic [15:0] cid;
		logic [31:0] specific;
		logic [14:0] status;
		logic [9:0] tag;
		logic [37:0] exp_word0;
		logic [35:0] exp_word1;
		int start_count;
		int waited;
		qid = 4'($urandom);
		cid = 16'($urandom);
		specific = $urandom;
		status = 15'($urandom);
		tag = 10'($urandom);
		if (cpl_type != 2'b00)
			exp_word0 = {status[12:0], qid, cid[15:7], tag, cpl_type};
		else
			exp_word0 = {3'b000, status[12:0], qid, cid, cpl_type};
		exp_word1 = {2'b00, specific, status[14:13]};

		start_count = push_count;
		axi_write(reg_addr(FIFO_BASE, 1), {12'b0, qid, cid});
		axi_write(reg_addr(FIFO_BASE, 2), specific);
		axi_write(reg_addr(FIFO_BASE, 3), {status, 1'b0, cpl_type, 4'b0, tag});
		repeat ($urandom_range(3, 20)) @(posedge s_axi_aclk); // fifo still full
		check_value("pushes while fifo full", push_count - start_count, 0);

		hcmd_cq_wr1_rdy_n <= 1'b0;
		waited = 0;
		while (push_count == start_count && waited < 10) begin
			@(posedge s_axi_aclk);
			waited++;
		end
		repeat (4) @(posedge s_axi_aclk);
		hcmd_cq_wr1_rdy_n <= 1'b1;
		check_value("pushes after fifo ready", push_count - start_count, 1);
		check_value("completion word 0", push_data0, exp_word0);
		check_value("completion word 1", push_data1, exp_word1);
		check_read(reg_addr(FIFO_BASE, 1), {12'b0, qid, cid}, "completion qid and cid");
	endtask

	task automatic test_control_outputs();
		int start_count;
		logic [31:0] csts;
		start_count = rst_pulse_count;
		axi_write(reg_addr(CNTL_BASE, 0), 32'h0000_0001);
		repeat (4) @(posedge s_axi_aclk);
		check_value("user logic reset pulses", rst_pulse_count - start_count, 1);

		csts = $urandom;
		axi_write(reg_addr(NVME_BASE, 0), csts);
		@(posedge s_axi_aclk); // new value from the next cycle
		check_value("nvme_csts_shst", nvme_csts_shst, csts[6:5]);
		check_value("nvme_csts_rdy", nvme_csts_rdy, csts[4]);
		check_value("reset_count", reset_count, csts[10:7]);
		check_read(reg_addr(NVME_BASE, 0),
			{25'b0, csts[6:5], csts[4], 1'b0, nvme_cc_shn, nvme_cc_en}, "nvme status word");
	endtask

	initial begin
		void'($urandom(49));
		error_count = 0;
		cycle_count = 0;
		push_count = 0;
		rst_pulse_count = 0;
		exp_sq_valid = '0;
		exp_cq_valid = '0;
		exp_irq_en = '0;
		s_axi_aclk = 1'b0;
		s_axi_aresetn = 1'b0;
		s_axi_awvalid = 1'b0;
		s_axi_awaddr = '0;
		s_axi_wvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_bready = 1'b0;
		s_axi_arvalid = 1'b0;
		s_axi_araddr = '0;
		s_axi_rready = 1'b0;
		pcie_link_up = 1'b0;
		nvme_cc_en = 1'b0;
		nvme_cc_shn = 2'b00;
		m0_axi_bresp_err = 1'b0;
		m0_axi_rresp_err = 1'b0;
		pcie_mreq_err = 1'b0;
		pcie_cpld_err = 1'b0;
		pcie_cpld_len_err = 1'b0;
		hcmd_cq_wr1_rdy_n = 1'b1; // fifo full until a push test releases it

		repeat (3) @(posedge s_axi_aclk);
		s_axi_aresetn <= 1'b1;
		@(posedge s_axi_aclk);

		test_reset();
		test_queue_config();
		test_queue_config();
		test_interrupts();
		test_cpl_push(2'($urandom_range(1, 3)));
		test_cpl_push(2'b00);
		test_control_outputs();

		repeat (2) @(posedge s_axi_aclk);
		$display("errors: %0d", error_count);
		if (error_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+common
common/axi_lite_pkg.sv
common/nvme_reg_pkg.sv
axi_lite/axi_lite_write_fsm.sv
axi_lite/axi_lite_read_fsm.sv
source/irq_ctrl.sv
nvme_regs/nvme_queue_regs.sv
nvme_regs/cpl_entry_regs.sv
source/nvme_host_regs_top.sv
bench/tb_nvme_host_regs.sv
